// File: project.f
+incdir+source
source/cache_pkg.sv
source/mem_pkg.sv
source/cache_if.sv
source/tag_store.sv
source/data_array.sv
source/write_buffer.sv
source/miss_unit.sv
source/cache_ctrl.sv
source/cache_top.sv
dv/cache_tb.sv

// File: Bender.yml
package:
  name: dcache

export_include_dirs:
  - source

sources:
  - include_dirs:
      - source
    files:
      - source/cache_pkg.sv
      - source/mem_pkg.sv
      - source/cache_if.sv
      - source/tag_store.sv
      - source/data_array.sv
      - source/write_buffer.sv
      - source/miss_unit.sv
      - source/cache_ctrl.sv
      - source/cache_top.sv
  - target: test
    files:
      - dv/cache_tb.sv

// File: dv/cache_tb.sv
// top testbench that runs table and random cache accesses against a bus model and golden memory
`default_nettype none

module cache_tb;

  localparam int          TBL_N    = 12;
  localparam int          RAND_N   = 200;
  localparam int          LIMIT    = (TBL_N + RAND_N) * 40; // cycles for the whole run
  localparam logic [1:0]  BUS_ANY  = 2'd0;
  localparam logic [1:0]  BUS_NONE = 2'd1;
  localparam logic [1:0]  BUS_READ = 2'd2;

  typedef struct packed {
    logic        we;
    logic [31:0] addr;
    logic [7:0]  strb;
    logic [63:0] data;
    logic [1:0]  bus;  // expected bus traffic
  } entry_t;

  logic         i_clk, i_rst, i_valid, i_we;
  logic [31:0]  i_addr;
  logic [7:0]   i_wstrb;
  logic [63:0]  i_wdata;
  logic         o_addr_ok, o_data_ok;
  logic [63:0]  o_rdata;
  logic         o_rd_req, i_rd_rdy, i_ret_valid, i_ret_last;
  logic [31:0]  o_rd_addr, o_wr_addr;
  logic [63:0]  i_ret_data;
  logic         o_wr_req, i_wr_rdy;
  logic [255:0] o_wr_data;

  logic [7:0]   gold [logic [31:0]];     // bytes written by stores
  logic [63:0]  bus_mem [logic [31:0]];  // words written back
  bit           stored [logic [31:0]];   // lines with stores since last write-back
  entry_t       tbl [TBL_N];
  logic [31:0]  cur_line;
  int unsigned  rd_count, wr_count, errors, checks, tests, cycles;

  cache_top dut_i (.*);

  always #4 i_clk = ~i_clk;

  // ------------------------------------------------------------
  // memory contents and reporting
  // ------------------------------------------------------------
  function automatic logic [63:0] fill_word(input logic [31:0] wa);
    return {wa ^ 32'h5A5A_A5A5, ~wa};
  endfunction

  function automatic logic [63:0] bus_word(input logic [31:0] wa);
    return bus_mem.exists(wa) ? bus_mem[wa] : fill_word(wa);
  endfunction

  function automatic logic [63:0] golden_word(input logic [31:0] addr);
    logic [31:0] wa;
    logic [63:0] w;
    wa = {addr[31:3], 3'b000};
    w  = fill_word(wa);
    for (int b = 0; b < 8; b++) begin
      if (gold.exists(wa + 32'(b))) w[8*b +: 8] = gold[wa + 32'(b)];
    end
    return w;
  endfunction

  function automatic entry_t make_entry(input logic we, input logic [31:0] addr,
                                        input logic [7:0] strb, input logic [63:0] data,
                                        input logic [1:0] bus);
    return {we, addr, strb, data, bus};
  endfunction

  task automatic flag_error(input string msg);
    errors++;
    $display("ERR %0t: %s", $time, msg);
  endtask

  task automatic note_failure(input string msg);
    errors++;
    $display("%s", msg);
  endtask

  // ------------------------------------------------------------
  // bus side memory model
  // ------------------------------------------------------------
  always @(posedge i_clk) i_wr_rdy <= ($urandom_range(3, 0) != 0);

  always @(negedge i_clk) begin
    if (o_wr_req) begin
      wr_count++;
      checks++;
      if (o_wr_addr[4:0] != 5'd0)
        flag_error($sformatf("unaligned write-back 0x%08h", o_wr_addr));
      if (!stored.exists(o_wr_addr))
        flag_error($sformatf("write-back of clean line 0x%08h", o_wr_addr));
      for (int k = 0; k < 4; k++) begin
        if (o_wr_data[64*k +: 64] !== golden_word(o_wr_addr + 32'(8*k)))
          flag_error($sformatf("write-back 0x%08h word %0d is 0x%016h", o_wr_addr, k,
                               o_wr_data[64*k +: 64]));
        bus_mem[o_wr_addr + 32'(8*k)] = o_wr_data[64*k +: 64];
      end
      stored.delete(o_wr_addr);
    end
  end

  initial begin
    int          delay;
    int          k;
    logic [31:0] base;
    forever begin
      @(negedge i_clk);
      if (o_rd_req) begin
        rd_count++;
        checks++;
        if (o_rd_addr !== cur_line)
          flag_error($sformatf("read address 0x%08h, expected 0x%08h", o_rd_addr, cur_line));
        base  = o_rd_addr;
        delay = $urandom_range(3, 0);
        repeat (delay) @(posedge i_clk);
        @(posedge i_clk);
        i_rd_rdy <= 1'b1;
        @(posedge i_clk);
        i_rd_rdy <= 1'b0;
        k = 0;
        while (k < 4) begin
          if ($urandom_range(3, 0) == 0) begin
            i_ret_valid <= 1'b0;  // gap
          end else begin
            i_ret_valid <= 1'b1;
            i_ret_data  <= bus_word(base + 32'(8*k));
            i_ret_last  <= (k == 3);
            k++;
          end
          @(posedge i_clk);
        end
        i_ret_valid <= 1'b0;
        i_ret_last  <= 1'b0;
      end
    end
  end

  always @(posedge i_clk) begin
    cycles <= cycles + 1;
    if (cycles >= LIMIT) begin
      $display("timeout: run did not finish within %0d cycles", LIMIT);
      $display("** FAIL **");
      $finish;
    end
  end

  // ------------------------------------------------------------
  // core side access
  // ------------------------------------------------------------
  task automatic run_access(input entry_t e);
    int unsigned rd0;
    int unsigned wr0;
    logic [63:0] exp;
    rd0      = rd_count;
    wr0      = wr_count;
    cur_line = {e.addr[31:5], 5'd0};
    @(posedge i_clk);
    i_valid <= 1'b1;
    i_we    <= e.we;
    i_addr  <= e.addr;
    i_wstrb <= e.strb;
    i_wdata <= e.data;
    @(negedge i_clk);
    while (!o_addr_ok) @(negedge i_clk);  // stall on buffer conflict
    @(posedge i_clk);
    i_valid <= 1'b0;
    @(negedge i_clk);
    while (!o_data_ok) @(negedge i_clk);
    if (e.we) begin
      for (int b = 0; b < 8; b++) begin
        if (e.strb[b]) gold[{e.addr[31:3], 3'b000} + 32'(b)] = e.data[8*b +: 8];
      end
      stored[cur_line] = 1'b1;
    end else begin
      exp = golden_word(e.addr);
      checks++;
      if (o_rdata !== exp)
        flag_error($sformatf("load 0x%08h returned 0x%016h, expected 0x%016h",
                             e.addr, o_rdata, exp));
    end
    checks++;
    if (e.bus == BUS_NONE && (rd_count != rd0 || wr_count != wr0))
      flag_error($sformatf("access 0x%08h hit but used the bus", e.addr));
    if (e.bus == BUS_READ && rd_count == rd0)
      flag_error($sformatf("access 0x%08h raised no line read", e.addr));
  endtask

  initial begin
    int unsigned err0;
    entry_t      e;
    void'($urandom(20));
    i_clk = 1'b0;
    i_rst = 1'b1;
    i_valid = 1'b0;
    i_we = 1'b0;
    i_addr = '0;
    i_wstrb = '0;
    i_wdata = '0;
    i_rd_rdy = 1'b0;
    i_ret_valid = 1'b0;
    i_ret_last = 1'b0;
    i_ret_data = '0;
    i_wr_rdy = 1'b0;
    cur_line = '0;
    // set 0 hits, then three lines of set 2
    tbl[0]  = make_entry(1'b0, 32'h0000_1000, 8'h00, 64'h0, BUS_READ);
    tbl[1]  = make_entry(1'b0, 32'h0000_1008, 8'h00, 64'h0, BUS_NONE);
    tbl[2]  = make_entry(1'b1, 32'h0000_1010, 8'h0F, 64'h1122_3344_5566_7788, BUS_NONE);
    tbl[3]  = make_entry(1'b0, 32'h0000_1010, 8'h00, 64'h0, BUS_NONE);
    tbl[4]  = make_entry(1'b1, 32'h0000_1048, 8'hF0, 64'hCAFE_F00D_0000_0000, BUS_READ);
    tbl[5]  = make_entry(1'b1, 32'h0000_1858, 8'hFF, 64'h0123_4567_89AB_CDEF, BUS_READ);
    tbl[6]  = make_entry(1'b0, 32'h0000_2040, 8'h00, 64'h0, BUS_READ);
    tbl[7]  = make_entry(1'b0, 32'h0000_1048, 8'h00, 64'h0, BUS_ANY);
    tbl[8]  = make_entry(1'b0, 32'h0000_1858, 8'h00, 64'h0, BUS_ANY);
    tbl[9]  = make_entry(1'b1, 32'h0000_2050, 8'h81, 64'hA0B0_C0D0_E0F0_0102, BUS_ANY);
    tbl[10] = make_entry(1'b0, 32'h0000_2050, 8'h00, 64'h0, BUS_ANY);
    tbl[11] = make_entry(1'b0, 32'h0000_1018, 8'h00, 64'h0, BUS_NONE);

    repeat (8) @(posedge i_clk);
    i_rst <= 1'b0;
    @(negedge i_clk);
    tests++;
    checks++;
    if (o_addr_ok !== 1'b1 || o_data_ok !== 1'b0 || o_rd_req !== 1'b0 || o_wr_req !== 1'b0)
      flag_error("handshake outputs wrong after reset");
    $display("test reset values: %s", (errors == 0) ? "ok" : "failed");

    for (int i = 0; i < TBL_N; i++) begin
      err0 = errors;
      tests++;
      run_access(tbl[i]);
      $display("test table %0d (%s 0x%08h): %s", i, tbl[i].we ? "store" : "load",
               tbl[i].addr, (errors == err0) ? "ok" : "failed");
    end
    if (wr_count == 0) note_failure("no write-back seen while evicting dirty lines in set 2");

    err0 = errors;
    tests++;
    for (int i = 0; i < RAND_N; i++) begin
      e.we   = 1'($urandom_range(1, 0));
      e.addr = (32'($urandom_range(4, 1)) << 11) | (32'($urandom_range(7, 0)) << 5)
               | (32'($urandom_range(3, 0)) << 3);
      e.strb = 8'($urandom_range(255, 1));
      e.data = {$urandom, $urandom};
      e.bus  = BUS_ANY;
      run_access(e);
    end
    $display("test random %0d accesses: %s", RAND_N, (errors == err0) ? "ok" : "failed");

    $display("tests %0d, checks %0d, errors %0d, line reads %0d, write-backs %0d",
             tests, checks, errors, rd_count, wr_count);
    if (errors == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: source/cache_top.sv
// data cache top level: core request port and memory line bus, instantiated by the SoC
`default_nettype none

`include "cache_cfg.svh"

module cache_top (
  input  wire logic                     i_clk,
  input  wire logic                     i_rst,
  // core side
  input  wire logic                     i_valid,
  input  wire logic                     i_we,
  input  wire logic [`CACHE_ADDR_W-1:0] i_addr,
  input  wire cache_pkg::strb_t         i_wstrb,
  input  wire cache_pkg::word_t         i_wdata,
  output logic                          o_addr_ok,
  output logic                          o_data_ok,
  output cache_pkg::word_t              o_rdata,
  // bus side
  output logic                          o_rd_req,
  output mem_pkg::line_addr_t           o_rd_addr,
  input  wire logic                     i_rd_rdy,
  input  wire logic                     i_ret_valid,
  input  wire logic                     i_ret_last,
  input  wire cache_pkg::word_t         i_ret_data,
  output logic                          o_wr_req,
  output mem_pkg::line_addr_t           o_wr_addr,
  output cache_pkg::line_t              o_wr_data,
  input  wire logic                     i_wr_rdy
);

  array_wr_if wb_wr ();
  array_wr_if fill_wr ();
  miss_if     miss ();

  logic                        hit;
  cache_pkg::way_t             hit_way;
  cache_pkg::line_t            rd_line [`CACHE_WAYS];
  logic                        rd_en;
  cache_pkg::index_t           rd_index;
  cache_pkg::req_t             req;
  cache_pkg::tag_t             way_tag [`CACHE_WAYS];
  logic [`CACHE_WAYS-1:0]      way_valid_dirty;
  logic                        fill_done;

  cache_ctrl ctrl_i (
    .i_clk, .i_rst, .i_valid, .i_we, .i_addr, .i_wstrb, .i_wdata,
    .o_addr_ok, .o_data_ok, .o_rdata,
    .i_hit_way (hit_way),
    .i_hit     (hit),
    .i_rd_line (rd_line),
    .o_rd_en   (rd_en),
    .o_rd_index(rd_index),
    .o_req     (req),
    .wb_wr     (wb_wr.mon),
    .miss      (miss.ctrl)
  );

  tag_store tag_i (
    .i_clk, .i_rst,
    .i_index          (req.index),
    .i_tag            (req.tag),
    .o_hit            (hit),
    .o_hit_way        (hit_way),
    .o_way_tag        (way_tag),
    .o_way_valid_dirty(way_valid_dirty),
    .i_fill_done      (fill_done),
    .wb_wr            (wb_wr.mon),
    .fill_wr          (fill_wr.mon)
  );

  data_array data_i (
    .i_clk,
    .i_rd_en   (rd_en),
    .i_rd_index(rd_index),
    .o_rd_line (rd_line),
    .wb_wr     (wb_wr.sink),
    .fill_wr   (fill_wr.sink)
  );

  // a completing store is captured with its hit way
  write_buffer wbuf_i (
    .i_clk, .i_rst,
    .i_capture(o_data_ok),
    .i_req    (req),
    .i_way    (hit_way),
    .wb_wr    (wb_wr.src)
  );

  miss_unit miss_i (
    .i_clk, .i_rst,
    .miss             (miss.miss),
    .i_way_tag        (way_tag),
    .i_way_valid_dirty(way_valid_dirty),
    .i_victim_line    (rd_line),
    .o_rd_req, .o_rd_addr, .i_rd_rdy, .i_ret_valid, .i_ret_last, .i_ret_data,
    .o_wr_req, .o_wr_addr, .o_wr_data, .i_wr_rdy,
    .o_fill_done      (fill_done),
    .fill_wr          (fill_wr.src)
  );

endmodule

`default_nettype wire

// File: source/cache_ctrl.sv
// main cache controller: request register, state machine, load select and core handshake
`default_nettype none

`include "cache_cfg.svh"

module cache_ctrl (
  input  wire logic                 i_clk,
  input  wire logic                 i_rst,
  input  wire logic                 i_valid,
  input  wire logic                 i_we,
  input  wire logic [`CACHE_ADDR_W-1:0] i_addr,
  input  wire cache_pkg::strb_t     i_wstrb,
  input  wire cache_pkg::word_t     i_wdata,
  output logic                      o_addr_ok,
  output logic                      o_data_ok,
  output cache_pkg::word_t          o_rdata,
  input  wire cache_pkg::way_t      i_hit_way,
  input  wire logic                 i_hit,
  input  wire cache_pkg::line_t     i_rd_line [`CACHE_WAYS],
  output logic                      o_rd_en,
  output cache_pkg::index_t         o_rd_index,
  output cache_pkg::req_t           o_req,
  array_wr_if.mon                   wb_wr,
  miss_if.ctrl                      miss
);

  cache_pkg::state_t    state;
  cache_pkg::req_t      req;
  cache_pkg::tag_t      in_tag;
  cache_pkg::index_t    in_index;
  cache_pkg::word_sel_t in_wsel;
  logic                 conflict;
  logic                 accept;
  logic                 start_q;

  // ------------------------------------------------------------
  // address split and acceptance
  // ------------------------------------------------------------
  assign in_wsel  = i_addr[cache_pkg::OFFSET_W-1 -: cache_pkg::WSEL_W];
  assign in_index = i_addr[cache_pkg::OFFSET_W +: cache_pkg::INDEX_W];
  assign in_tag   = i_addr[cache_pkg::OFFSET_W+cache_pkg::INDEX_W +: cache_pkg::TAG_W];

  // pending store to the same word still on its way into the array
  assign conflict  = wb_wr.en && wb_wr.index == in_index && wb_wr.word == in_wsel;
  assign o_addr_ok = (state == cache_pkg::IDLE) && !conflict;
  assign accept    = i_valid && o_addr_ok;

  assign o_rd_en    = accept || (state == cache_pkg::RESTART);
  assign o_rd_index = (state == cache_pkg::RESTART) ? req.index : in_index;

  always_ff @(posedge i_clk) begin
    if (accept) begin
      req <= '{we: i_we, tag: in_tag, index: in_index, wsel: in_wsel,
               strb: i_wstrb, wdata: i_wdata};
    end
  end

  assign o_req = req;

  // ------------------------------------------------------------
  // completion and load data
  // ------------------------------------------------------------
  assign o_data_ok = (state == cache_pkg::LOOKUP) && i_hit;
  assign o_rdata   = i_rd_line[i_hit_way][req.wsel*`CACHE_WORD_W +: `CACHE_WORD_W];

  assign miss.start = start_q;
  assign miss.index = req.index;
  assign miss.tag   = req.tag;

  // ------------------------------------------------------------
  // state machine
  // ------------------------------------------------------------
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      state   <= cache_pkg::IDLE;
      start_q <= 1'b0;
    end else begin
      start_q <= (state == cache_pkg::LOOKUP) && !i_hit; // high in first MISS cycle
      case (state)
        cache_pkg::IDLE:    if (accept) state <= cache_pkg::LOOKUP;
        cache_pkg::LOOKUP:  state <= i_hit ? cache_pkg::IDLE : cache_pkg::MISS;
        // miss unit runs write-back, line read and refill meanwhile
        cache_pkg::MISS:    if (miss.done) state <= cache_pkg::RESTART;
        cache_pkg::RESTART: state <= cache_pkg::LOOKUP; // array read reissued
        default:            state <= cache_pkg::IDLE;
      endcase
    end
  end

endmodule

`default_nettype wire

// File: source/miss_unit.sv
// miss handling: victim choice, dirty write-back, line read and refill into the array
`default_nettype none

`include "cache_cfg.svh"

module miss_unit (
  input  wire logic                i_clk,
  input  wire logic                i_rst,
  miss_if.miss                     miss,
  input  wire cache_pkg::tag_t     i_way_tag [`CACHE_WAYS],
  input  wire logic [`CACHE_WAYS-1:0] i_way_valid_dirty,
  input  wire cache_pkg::line_t    i_victim_line [`CACHE_WAYS],
  output logic                     o_rd_req,
  output mem_pkg::line_addr_t      o_rd_addr,
  input  wire logic                i_rd_rdy,
  input  wire logic                i_ret_valid,
  input  wire logic                i_ret_last,
  input  wire cache_pkg::word_t    i_ret_data,
  output logic                     o_wr_req,
  output mem_pkg::line_addr_t      o_wr_addr,
  output cache_pkg::line_t         o_wr_data,
  input  wire logic                i_wr_rdy,
  output logic                     o_fill_done,
  array_wr_if.src                  fill_wr
);

  cache_pkg::state_t phase;   // IDLE, MISS, REPLACE, REFILL
  cache_pkg::way_t   toggle;  // free running victim pick
  cache_pkg::way_t   vic_way;
  mem_pkg::beat_t    beat;
  logic              need_wb;

  assign need_wb   = i_way_valid_dirty[vic_way];

  // ------------------------------------------------------------
  // bus side
  // ------------------------------------------------------------
  assign o_wr_req  = (phase == cache_pkg::MISS) && need_wb && i_wr_rdy;
  assign o_wr_addr = {i_way_tag[vic_way], miss.index, {cache_pkg::OFFSET_W{1'b0}}};
  assign o_wr_data = i_victim_line[vic_way]; // read still held from acceptance
  assign o_rd_req  = (phase == cache_pkg::REPLACE);
  assign o_rd_addr = {miss.tag, miss.index, {cache_pkg::OFFSET_W{1'b0}}};

  // ------------------------------------------------------------
  // refill writes, one full word per beat
  // ------------------------------------------------------------
  assign fill_wr.en    = (phase == cache_pkg::REFILL) && i_ret_valid;
  assign fill_wr.way   = vic_way;
  assign fill_wr.index = miss.index;
  assign fill_wr.word  = beat;
  assign fill_wr.strb  = '1;
  assign fill_wr.data  = i_ret_data;
  assign o_fill_done   = fill_wr.en && i_ret_last;
  assign miss.done     = o_fill_done;

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      phase  <= cache_pkg::IDLE;
      toggle <= '0;
    end else begin
      toggle <= toggle + 1'b1;
      case (phase)
        cache_pkg::IDLE:    if (miss.start) phase <= cache_pkg::MISS;
        cache_pkg::MISS:    if (!need_wb || i_wr_rdy) phase <= cache_pkg::REPLACE; // wb pulse
        cache_pkg::REPLACE: if (i_rd_rdy) phase <= cache_pkg::REFILL;
        cache_pkg::REFILL:  if (o_fill_done) phase <= cache_pkg::IDLE;
        default:            phase <= cache_pkg::IDLE;
      endcase
    end
  end

  always_ff @(posedge i_clk) begin
    if (miss.start) begin
      vic_way <= toggle;
    end
    if (phase == cache_pkg::REPLACE) begin
      beat <= '0;             // words return from word 0
    end else if (fill_wr.en) begin
      beat <= beat + 1'b1;
    end
  end

endmodule

`default_nettype wire

// File: source/write_buffer.sv
// one-entry store buffer that writes a store hit into the data array one cycle later
`default_nettype none

module write_buffer (
  input  wire logic            i_clk,
  input  wire logic            i_rst,
  input  wire logic            i_capture, // request completes this cycle
  input  wire cache_pkg::req_t i_req,
  input  wire cache_pkg::way_t i_way,
  array_wr_if.src              wb_wr
);

  logic                 pend;
  cache_pkg::way_t      way;
  cache_pkg::index_t    index;
  cache_pkg::word_sel_t word;
  cache_pkg::strb_t     strb;
  cache_pkg::word_t     data;

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      pend <= 1'b0;
    end else begin
      pend <= i_capture & i_req.we; // loads pass through untouched
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_capture && i_req.we) begin
      way   <= i_way;
      index <= i_req.index;
      word  <= i_req.wsel;
      strb  <= i_req.strb;
      data  <= i_req.wdata;
    end
  end

  assign wb_wr.en    = pend;
  assign wb_wr.way   = way;
  assign wb_wr.index = index;
  assign wb_wr.word  = word;
  assign wb_wr.strb  = strb;
  assign wb_wr.data  = data;

endmodule

`default_nettype wire

// File: source/data_array.sv
// two-way line storage, synchronous read of both ways, byte-masked word writes
`default_nettype none

`include "cache_cfg.svh"

module data_array (
  input  wire logic           i_clk,
  input  wire logic           i_rd_en,
  input  wire cache_pkg::index_t i_rd_index,
  output cache_pkg::line_t    o_rd_line [`CACHE_WAYS],
  array_wr_if.sink            wb_wr,
  array_wr_if.sink            fill_wr
);

  cache_pkg::line_t     mem [`CACHE_WAYS][`CACHE_SETS];

  logic                 wr_en;
  cache_pkg::way_t      wr_way;
  cache_pkg::index_t    wr_index;
  cache_pkg::word_sel_t wr_word;
  cache_pkg::strb_t     wr_strb;
  cache_pkg::word_t     wr_data;
  cache_pkg::line_t     wr_mask;
  cache_pkg::line_t     wr_line;

  function automatic cache_pkg::line_t merge(input cache_pkg::line_t old);
    return (old & ~wr_mask) | (wr_line & wr_mask);
  endfunction

  // the two write sources are never active together
  assign wr_en    = wb_wr.en | fill_wr.en;
  assign wr_way   = wb_wr.en ? wb_wr.way   : fill_wr.way;
  assign wr_index = wb_wr.en ? wb_wr.index : fill_wr.index;
  assign wr_word  = wb_wr.en ? wb_wr.word  : fill_wr.word;
  assign wr_strb  = wb_wr.en ? wb_wr.strb  : fill_wr.strb;
  assign wr_data  = wb_wr.en ? wb_wr.data  : fill_wr.data;

  always_comb begin
    wr_mask = '0;
    wr_line = '0;
    for (int b = 0; b < cache_pkg::WORD_BYTES; b++) begin
      wr_mask[wr_word*`CACHE_WORD_W + b*8 +: 8] = {8{wr_strb[b]}};
    end
    wr_line[wr_word*`CACHE_WORD_W +: `CACHE_WORD_W] = wr_data;
  end

  always_ff @(posedge i_clk) begin
    if (wr_en) begin
      mem[wr_way][wr_index] <= merge(mem[wr_way][wr_index]);
    end
    if (i_rd_en) begin
      for (int w = 0; w < `CACHE_WAYS; w++) begin
        // a write to the same line in this cycle shows up in the read
        if (wr_en && wr_way == cache_pkg::way_t'(w) && wr_index == i_rd_index)
          o_rd_line[w] <= merge(mem[w][i_rd_index]);
        else
          o_rd_line[w] <= mem[w][i_rd_index];
      end
    end
  end

endmodule

`default_nettype wire

// File: source/tag_store.sv
// tag, valid and dirty storage with hit compare and victim info per way
`default_nettype none

`include "cache_cfg.svh"

module tag_store (
  input  wire logic                    i_clk,
  input  wire logic                    i_rst,
  input  wire cache_pkg::index_t       i_index,
  input  wire cache_pkg::tag_t         i_tag,
  output logic                         o_hit,
  output cache_pkg::way_t              o_hit_way,
  output cache_pkg::tag_t              o_way_tag [`CACHE_WAYS],
  output logic [`CACHE_WAYS-1:0]       o_way_valid_dirty,
  input  wire logic                    i_fill_done,
  array_wr_if.mon                      wb_wr,
  array_wr_if.mon                      fill_wr
);

  cache_pkg::tag_t         tags  [`CACHE_WAYS][`CACHE_SETS];
  logic [`CACHE_SETS-1:0]  valid [`CACHE_WAYS];
  logic [`CACHE_SETS-1:0]  dirty [`CACHE_WAYS];

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      for (int w = 0; w < `CACHE_WAYS; w++) begin
        valid[w] <= '0;
        dirty[w] <= '0;
      end
    end else begin
      if (wb_wr.en) begin
        dirty[wb_wr.way][wb_wr.index] <= 1'b1; // store hit lands
      end
      if (i_fill_done) begin
        valid[fill_wr.way][fill_wr.index] <= 1'b1;
        dirty[fill_wr.way][fill_wr.index] <= 1'b0; // fresh line is clean
      end
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_fill_done) begin
      tags[fill_wr.way][fill_wr.index] <= i_tag;
    end
  end

  // compare against the registered request
  always_comb begin
    o_hit     = 1'b0;
    o_hit_way = '0;
    for (int w = 0; w < `CACHE_WAYS; w++) begin
      o_way_tag[w]         = tags[w][i_index];
      o_way_valid_dirty[w] = valid[w][i_index] & dirty[w][i_index];
      if (valid[w][i_index] && tags[w][i_index] == i_tag) begin
        o_hit     = 1'b1;
        o_hit_way = cache_pkg::way_t'(w);
      end
    end
  end

endmodule

`default_nettype wire

// File: source/cache_if.sv
// array write and miss handshake interfaces connecting the cache units
`default_nettype none

`include "cache_cfg.svh"

// ------------------------------------------------------------
// single word write into the data array
// ------------------------------------------------------------
interface array_wr_if;
  logic                                                en;   // one-cycle strobe
  logic [$clog2(`CACHE_WAYS)-1:0]                      way;
  logic [$clog2(`CACHE_SETS)-1:0]                      index;
  logic [$clog2(`CACHE_LINE_BYTES*8/`CACHE_WORD_W)-1:0] word;
  logic [`CACHE_WORD_W/8-1:0]                          strb;
  logic [`CACHE_WORD_W-1:0]                            data;

  modport src  (output en, way, index, word, strb, data);
  modport sink (input en, way, index, word, strb, data);
  modport mon  (input en, way, index, word);
endinterface

// ------------------------------------------------------------
// controller to miss unit
// ------------------------------------------------------------
interface miss_if;
  logic                                                            start; // first MISS cycle
  logic [$clog2(`CACHE_SETS)-1:0]                                  index;
  logic [`CACHE_ADDR_W-$clog2(`CACHE_SETS)-$clog2(`CACHE_LINE_BYTES)-1:0] tag;
  logic                                                            done;  // last refill beat

  modport ctrl (output start, index, tag, input done);
  modport miss (input start, index, tag, output done);
endinterface

`default_nettype wire

// File: source/mem_pkg.sv
// memory bus types for line transfers between the cache and the bus
`default_nettype none

`include "cache_cfg.svh"

package mem_pkg;

  localparam int BEATS = `CACHE_LINE_BYTES / (`CACHE_WORD_W / 8); // words per line

  typedef logic [`CACHE_ADDR_W-1:0]  line_addr_t; // low offset bits always zero
  typedef logic [$clog2(BEATS)-1:0]  beat_t;

endpackage

`default_nettype wire

// File: source/cache_pkg.sv
// cache organization types shared by the controller, arrays and buffers
`default_nettype none

`include "cache_cfg.svh"

package cache_pkg;

  localparam int WORD_BYTES = `CACHE_WORD_W / 8;
  localparam int LINE_WORDS = `CACHE_LINE_BYTES / WORD_BYTES;
  localparam int OFFSET_W   = $clog2(`CACHE_LINE_BYTES); // byte offset in line
  localparam int INDEX_W    = $clog2(`CACHE_SETS);
  localparam int TAG_W      = `CACHE_ADDR_W - INDEX_W - OFFSET_W;
  localparam int WSEL_W     = $clog2(LINE_WORDS);         // addr bits 4:3

  typedef logic [`CACHE_WORD_W-1:0]        word_t;
  typedef logic [WORD_BYTES-1:0]           strb_t;
  typedef logic [INDEX_W-1:0]              index_t;
  typedef logic [TAG_W-1:0]                tag_t;
  typedef logic [WSEL_W-1:0]               word_sel_t;
  typedef logic [$clog2(`CACHE_WAYS)-1:0]  way_t;
  typedef logic [`CACHE_LINE_BYTES*8-1:0]  line_t;

  // one accepted core request
  typedef struct packed {
    logic      we;
    tag_t      tag;
    index_t    index;
    word_sel_t wsel;
    strb_t     strb;
    word_t     wdata;
  } req_t;

  typedef enum logic [2:0] {
    IDLE,
    LOOKUP,
    MISS,
    REPLACE,
    REFILL,
    RESTART
  } state_t;

endpackage

`default_nettype wire

// File: source/cache_cfg.svh
// cache geometry macros, included by both packages and by any RTL file that sizes arrays
`ifndef CACHE_CFG_SVH
`define CACHE_CFG_SVH

`define CACHE_ADDR_W     32 // byte address bits
`define CACHE_WORD_W     64 // core data word
`define CACHE_LINE_BYTES 32 // four words per line
`define CACHE_WAYS       2
`define CACHE_SETS       64

`endif
